// File: bpred_top.f
src/p_bpred.sv
src/bpred_stage_if.sv
src/bop.sv
src/bpred_decode.sv
src/bpred_execute.sv
src/bpred_result.sv
src/bpred_top.sv
tests/bpred_props.sv
tests/bpred_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bpred_tb -f bpred_top.f -o sim_bpred \
   && ./obj_dir/sim_bpred +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Result: FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation complete"

// File: src/bop.sv
/*
   buffer of predictions
   short shifting FIFO of predicted targets, one occupancy bit
   per slot, entries drift toward the head while space ahead frees
*/
`default_nettype none

module bop import p_bpred::*; #(
   parameter int SIZE = 3                            // number of slots
) (
   input  logic                 s_clk_i,
   input  logic                 rst_n_i,
   input  logic                 s_flush_i,           // drop all entries
   input  logic                 s_push_i,            // write s_data_i into slot 0
   input  logic                 s_pop_i,             // head consumed
   input  logic [BOP_WIDTH-1:0] s_data_i,            // predicted target in
   output logic [BOP_WIDTH-1:0] s_data_o,            // head entry
   output logic                 s_entry_ready_o,     // head slot occupied
   output logic                 s_full_o,            // all slots occupied
   output logic                 s_afull_o            // exactly one slot free
);

   logic [BOP_WIDTH-1:0] slot_q [SIZE];              // slot SIZE-1 is the head
   logic [SIZE-1:0]      occ_q;                      // occupancy per slot
   logic [SIZE-1:0]      occ_d;
   logic [SIZE-1:0]      go;                         // slot content leaves this cycle

   assign s_data_o        = slot_q[SIZE-1];
   assign s_entry_ready_o = occ_q[SIZE-1];
   assign s_full_o        = &occ_q;
   assign s_afull_o       = ($countones(occ_q) == SIZE - 1);   // one slot still free

   // move chain resolved from the head backwards
   always_comb begin
      go[SIZE-1] = s_pop_i & occ_q[SIZE-1];          // head leaves only on pop
      for (int i = SIZE - 2; i >= 0; i--) begin
         go[i] = occ_q[i] & (~occ_q[i+1] | go[i+1]); // next slot free or freeing
      end
   end

   // next occupancy with slot 0 refilled by push
   always_comb begin
      occ_d[0] = s_push_i | (occ_q[0] & ~go[0]);
      for (int i = 1; i < SIZE; i++) begin
         occ_d[i] = go[i-1] | (occ_q[i] & ~go[i]);   // filled from behind or kept
      end
   end

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         occ_q <= '0;
      end else if (s_flush_i) begin
         occ_q <= '0;                                // flush wins over push
      end else begin
         occ_q <= occ_d;
      end
   end

   // target storage
   always_ff @(posedge s_clk_i) begin
      if (s_push_i) begin
         slot_q[0] <= s_data_i;
      end
      for (int i = 1; i < SIZE; i++) begin
         if (go[i-1]) begin
            slot_q[i] <= slot_q[i-1];                // shift one slot forward
         end
      end
   end

endmodule

`default_nettype wire

// File: src/bpred_decode.sv
/*
   decode stage
   accepts issued instructions, applies the static prediction,
   pushes taken targets into the buffer and hands the bundle on
*/
`default_nettype none

module bpred_decode import p_bpred::*; (
   input  logic                 s_clk_i,
   input  logic                 rst_n_i,
   input  logic                 issue_valid_i,
   input  logic [XLEN-1:0]      issue_pc_i,
   input  op_e                  issue_op_i,
   input  logic [OFF_WIDTH-1:0] issue_offset_i,
   input  logic [XLEN-1:0]      issue_a_i,
   input  logic [XLEN-1:0]      issue_b_i,
   input  logic                 flush_i,             // kill everything in flight
   input  logic                 bop_full_i,          // no room for a target
   output logic                 issue_ready_o,
   output logic                 push_o,
   output logic [XLEN-1:0]      push_target_o,
   bpred_stage_if.src           de
);

   logic                 accept;                     // issue handshake completes
   logic                 pred_taken;                 // static rule outcome
   logic                 is_branch;
   logic                 lat_valid_q;                // issue latch
   logic [XLEN-1:0]      lat_pc_q;
   op_e                  lat_op_q;
   logic [OFF_WIDTH-1:0] lat_offset_q;
   logic [XLEN-1:0]      lat_a_q;
   logic [XLEN-1:0]      lat_b_q;
   logic                 lat_pred_q;

   assign issue_ready_o = ~bop_full_i & ~flush_i;
   assign accept        = issue_valid_i & issue_ready_o;
   assign is_branch     = (issue_op_i == OP_BEQ) | (issue_op_i == OP_BNE);
   // jumps and backward branches predicted taken
   assign pred_taken    = (issue_op_i == OP_JAL) | (is_branch & issue_offset_i[OFF_WIDTH-1]);
   assign push_o        = accept & pred_taken;       // written on the accept edge
   assign push_target_o = issue_pc_i + sext_off(issue_offset_i);

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lat_valid_q <= 1'b0;
         de.valid    <= 1'b0;
      end else begin
         lat_valid_q <= accept & ~flush_i;
         de.valid    <= lat_valid_q & ~flush_i;      // bundle out one cycle after accept
      end
   end

   always_ff @(posedge s_clk_i) begin
      lat_pc_q      <= issue_pc_i;
      lat_op_q      <= issue_op_i;
      lat_offset_q  <= issue_offset_i;
      lat_a_q       <= issue_a_i;
      lat_b_q       <= issue_b_i;
      lat_pred_q    <= pred_taken;
      de.pc         <= lat_pc_q;
      de.op         <= lat_op_q;
      de.offset     <= lat_offset_q;
      de.a          <= lat_a_q;
      de.b          <= lat_b_q;
      de.pred_taken <= lat_pred_q;
   end

endmodule

`default_nettype wire

// File: src/bpred_execute.sv
/*
   execute stage
   resolves the branch condition and the real next address,
   registered next to the instruction bundle
*/
`default_nettype none

module bpred_execute import p_bpred::*; (
   input  logic            s_clk_i,
   input  logic            rst_n_i,
   input  logic            flush_i,                  // invalidate stage register
   bpred_stage_if.dst      de,
   bpred_stage_if.src      ex,
   output logic            ex_taken_o,               // real outcome
   output logic [XLEN-1:0] ex_target_o               // real next address
);

   logic            taken;
   logic [XLEN-1:0] target;

   // condition from operands
   always_comb begin
      unique case (de.op)
         OP_JAL:  taken = 1'b1;
         OP_BEQ:  taken = (de.a == de.b);
         OP_BNE:  taken = (de.a != de.b);
         default: taken = 1'b0;                      // alu never transfers
      endcase
   end

   assign target = taken ? (de.pc + sext_off(de.offset))
                         : (de.pc + XLEN'(INSTR_BYTES));   // fall through

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex.valid <= 1'b0;
      end else begin
         ex.valid <= de.valid & ~flush_i;
      end
   end

   always_ff @(posedge s_clk_i) begin
      ex.pc         <= de.pc;
      ex.op         <= de.op;
      ex.offset     <= de.offset;
      ex.a          <= de.a;
      ex.b          <= de.b;
      ex.pred_taken <= de.pred_taken;
      ex_taken_o    <= taken;
      ex_target_o   <= target;
   end

endmodule

`default_nettype wire

// File: src/bpred_result.sv
/*
   result stage
   pops predicted targets, compares against the real outcome,
   reports each resolved instruction and raises flush on mispredict
*/
`default_nettype none

module bpred_result import p_bpred::*; (
   input  logic                 s_clk_i,
   input  logic                 rst_n_i,
   bpred_stage_if.dst           ex,
   input  logic                 ex_taken_i,
   input  logic [XLEN-1:0]      ex_target_i,
   input  logic [BOP_WIDTH-1:0] bop_data_i,          // head of buffer
   input  logic                 bop_ready_i,         // head valid
   output logic                 pop_o,
   output logic                 flush_o,
   output logic                 res_valid_o,
   output logic [XLEN-1:0]      res_pc_o,
   output logic                 res_taken_o,
   output logic [XLEN-1:0]      res_target_o,
   output logic                 res_mispredict_o
);

   logic live;                                       // instruction survives flush
   logic mispredict;

   assign live    = ex.valid & ~flush_o;             // younger work dies in flush cycle
   assign pop_o   = live & ex.pred_taken & bop_ready_i;
   assign flush_o = res_mispredict_o;

   // missing entry or wrong target also counts as mispredict
   assign mispredict = live & (ex.pred_taken ?
                       (~bop_ready_i | ~ex_taken_i | (bop_data_i != ex_target_i)) :
                       ex_taken_i);

   always_ff @(posedge s_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         res_valid_o      <= 1'b0;
         res_mispredict_o <= 1'b0;
      end else begin
         res_valid_o      <= live;
         res_mispredict_o <= mispredict;             // one cycle pulse
      end
   end

   always_ff @(posedge s_clk_i) begin
      res_pc_o     <= ex.pc;
      res_taken_o  <= ex_taken_i;
      res_target_o <= ex_target_i;
   end

endmodule

`default_nettype wire

// File: src/bpred_stage_if.sv
/*
   pipeline stage bundle
   one instruction with its operands and static prediction,
   passed from a producing stage to the consuming stage
*/
`default_nettype none

interface bpred_stage_if import p_bpred::*; ();

   logic                 valid;        // stage holds a live instruction
   logic [XLEN-1:0]      pc;           // instruction address
   op_e                  op;           // opcode
   logic [OFF_WIDTH-1:0] offset;       // raw signed offset
   logic [XLEN-1:0]      a;            // first operand
   logic [XLEN-1:0]      b;            // second operand
   logic                 pred_taken;   // decode predicted taken

   modport src (
      output valid, pc, op, offset, a, b, pred_taken
   );

   modport dst (
      input  valid, pc, op, offset, a, b, pred_taken
   );

endinterface

`default_nettype wire

// File: src/bpred_top.sv
/*
   branch resolution slice
   decode, execute and result stages around the buffer of predictions
*/
`default_nettype none

module bpred_top import p_bpred::*; #(
   parameter int BOP_SIZE = 3                        // buffer depth, 2 or 3
) (
   input  logic                 s_clk_i,
   input  logic                 rst_n_i,
   input  logic                 issue_valid_i,
   input  logic [XLEN-1:0]      issue_pc_i,
   input  op_e                  issue_op_i,
   input  logic [OFF_WIDTH-1:0] issue_offset_i,
   input  logic [XLEN-1:0]      issue_a_i,
   input  logic [XLEN-1:0]      issue_b_i,
   output logic                 issue_ready_o,
   output logic                 res_valid_o,
   output logic [XLEN-1:0]      res_pc_o,
   output logic                 res_taken_o,
   output logic [XLEN-1:0]      res_target_o,
   output logic                 res_mispredict_o
);

   logic                 push;
   logic [XLEN-1:0]      push_target;
   logic                 pop;
   logic                 flush;
   logic [BOP_WIDTH-1:0] bop_data;
   logic                 bop_ready;
   logic                 bop_full;
   logic                 ex_taken;
   logic [XLEN-1:0]      ex_target;

   bpred_stage_if de_if ();                          // decode to execute
   bpred_stage_if ex_if ();                          // execute to result

   bpred_decode u_decode (
      .s_clk_i, .rst_n_i, .issue_valid_i, .issue_pc_i, .issue_op_i,
      .issue_offset_i, .issue_a_i, .issue_b_i,
      .flush_i(flush), .bop_full_i(bop_full), .issue_ready_o,
      .push_o(push), .push_target_o(push_target), .de(de_if)
   );

   bpred_execute u_execute (
      .s_clk_i, .rst_n_i, .flush_i(flush), .de(de_if), .ex(ex_if),
      .ex_taken_o(ex_taken), .ex_target_o(ex_target)
   );

   bpred_result u_result (
      .s_clk_i, .rst_n_i, .ex(ex_if), .ex_taken_i(ex_taken), .ex_target_i(ex_target),
      .bop_data_i(bop_data), .bop_ready_i(bop_ready), .pop_o(pop), .flush_o(flush),
      .res_valid_o, .res_pc_o, .res_taken_o, .res_target_o, .res_mispredict_o
   );

   bop #(.SIZE(BOP_SIZE)) u_bop (
      .s_clk_i, .rst_n_i, .s_flush_i(flush), .s_push_i(push), .s_pop_i(pop),
      .s_data_i(push_target), .s_data_o(bop_data), .s_entry_ready_o(bop_ready),
      .s_full_o(bop_full), .s_afull_o()               // almost full unused here
   );

endmodule

`default_nettype wire

// File: src/p_bpred.sv
/*
   branch prediction package
   widths, address step, opcode encoding and the offset
   sign extension shared by the pipeline stages
*/
`default_nettype none

package p_bpred;

   parameter int unsigned XLEN        = 32;          // address and operand width
   parameter int unsigned BOP_WIDTH   = XLEN;        // one buffer entry holds a target
   parameter int unsigned OFF_WIDTH   = 13;          // signed branch offset
   parameter int unsigned INSTR_BYTES = 4;           // sequential pc step

   // control transfer opcodes
   typedef enum logic [1:0] {
      OP_ALU = 2'b00,                                 // no control transfer
      OP_JAL = 2'b01,                                 // unconditional jump
      OP_BEQ = 2'b10,                                 // taken if a == b
      OP_BNE = 2'b11                                  // taken if a != b
   } op_e;

   // widen a branch offset to address width
   function automatic logic [XLEN-1:0] sext_off(input logic [OFF_WIDTH-1:0] off);
      return {{(XLEN-OFF_WIDTH){off[OFF_WIDTH-1]}}, off};   // replicate sign bit
   endfunction

endpackage

`default_nettype wire

// File: tests/bpred_props.sv
/*
   buffer of predictions properties
   no push when full, no pop from an empty head, flush empties the slots
*/
`default_nettype none

module bpred_props #(
   parameter int SIZE = 3                            // depth of the bound buffer
) (
   input logic            clk_i,
   input logic            rst_n_i,
   input logic            flush_i,
   input logic            push_i,
   input logic            pop_i,
   input logic            full_i,
   input logic            entry_ready_i,
   input logic [SIZE-1:0] occ_i                      // occupancy bits
);

   int unsigned fail_count = 0;                      // failed assertions so far

   push_room: assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_i)
      else begin
         $error("push while the buffer is full");
         fail_count++;
      end

   pop_head: assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> entry_ready_i)
      else begin
         $error("pop without a ready head entry");
         fail_count++;
      end

   // occupancy gone one edge after the flush cycle
   flush_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                 flush_i |=> occ_i == '0)
      else begin
         $error("occupancy not cleared after flush");
         fail_count++;
      end

endmodule

bind bop bpred_props #(.SIZE(SIZE)) u_props (
   .clk_i(s_clk_i), .rst_n_i(rst_n_i), .flush_i(s_flush_i), .push_i(s_push_i),
   .pop_i(s_pop_i), .full_i(s_full_o), .entry_ready_i(s_entry_ready_o), .occ_i(occ_q)
);

`default_nettype wire

// File: tests/bpred_tb.sv
/*
   testbench for the branch resolution slice
   random issue stream from an LCG, reference model of the
   prediction, resolution and flush rules, watchdog
*/
`default_nettype none

module bpred_tb import p_bpred::*; ();

   localparam int BOP_SIZE   = 3;
   localparam int CLK_PERIOD = 8;
   localparam int N_INSTR    = 2000;

   typedef struct packed {
      logic [31:0]     due;                          // negedge index of the result
      logic [XLEN-1:0] pc;
      logic            pred_taken;
      logic            taken;
      logic [XLEN-1:0] target;
      logic            mispredict;
   } expect_t;

   logic                 clk;
   logic                 rst_n;
   logic                 issue_valid;
   logic                 issue_ready;
   op_e                  issue_op;
   logic [OFF_WIDTH-1:0] issue_offset;
   logic [XLEN-1:0]      issue_pc, issue_a, issue_b;
   logic                 res_valid, res_taken, res_mispredict;
   logic [XLEN-1:0]      res_pc, res_target;
   logic [31:0]          rng_state = 32'h59c8_6abf;
   logic                 accepted = 1'b0;            // handshake seen at this negedge
   expect_t              exp_q[$];                   // in flight, oldest first
   int unsigned          cyc = 0;
   int unsigned          n_accepted = 0;
   int unsigned          n_flushes = 0;
   int unsigned          value_errors = 0;
   int unsigned          other_errors = 0;

   bpred_top #(.BOP_SIZE(BOP_SIZE)) dut0 (
      .s_clk_i(clk), .rst_n_i(rst_n), .issue_valid_i(issue_valid), .issue_pc_i(issue_pc),
      .issue_op_i(issue_op), .issue_offset_i(issue_offset), .issue_a_i(issue_a),
      .issue_b_i(issue_b), .issue_ready_o(issue_ready), .res_valid_o(res_valid),
      .res_pc_o(res_pc), .res_taken_o(res_taken), .res_target_o(res_target),
      .res_mispredict_o(res_mispredict)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // expectation from the prediction and resolution rules
   function automatic expect_t model_instr(input logic [31:0] due);
      expect_t e;
      e.due        = due;
      e.pc         = issue_pc;
      e.pred_taken = (issue_op == OP_JAL) || (issue_op != OP_ALU && issue_offset[OFF_WIDTH-1]);
      e.taken      = (issue_op == OP_JAL) || (issue_op == OP_BEQ && issue_a == issue_b)
                     || (issue_op == OP_BNE && issue_a != issue_b);
      e.target     = e.taken ? issue_pc + XLEN'($signed(issue_offset)) : issue_pc + XLEN'(4);
      e.mispredict = e.pred_taken != e.taken;
      return e;
   endfunction

   task automatic new_issue();
      logic [31:0] r_ctl;
      logic [31:0] r_pc;
      r_ctl        = next_rand();
      r_pc         = next_rand();
      issue_valid  = (r_ctl[31:24] < 8'd179) && (n_accepted < N_INSTR);   // about 70 percent
      issue_op     = op_e'(r_ctl[23:22]);
      issue_offset = {r_ctl[12:2], 2'b00};           // both signs, word aligned
      issue_pc     = {r_pc[31:2], 2'b00};
      issue_a      = next_rand();
      issue_b      = r_ctl[21] ? issue_a : next_rand();   // half equal
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, want, got);
      value_errors++;
   endtask

   // outputs after edge cyc against the model
   task automatic check_cycle();
      expect_t e;
      logic    flush_now;
      int      pend;
      flush_now = 1'b0;
      pend      = 0;
      if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
         e = exp_q.pop_front();
         if (!res_valid) begin
            $display("t=%0t: no result for the instruction at pc %h", $time, e.pc);
            other_errors++;
         end else begin
            if (res_pc !== e.pc)
               report_mismatch("res_pc_o", res_pc, e.pc);
            if (res_taken !== e.taken)
               report_mismatch("res_taken_o", 32'(res_taken), 32'(e.taken));
            if (res_target !== e.target)
               report_mismatch("res_target_o", res_target, e.target);
         end
         if (res_mispredict !== e.mispredict)
            report_mismatch("res_mispredict_o", 32'(res_mispredict), 32'(e.mispredict));
         if (e.mispredict) begin
            flush_now = 1'b1;
            n_flushes++;
            exp_q.delete();                          // younger work never resolves
         end
      end else begin
         if (res_valid) begin
            $display("t=%0t: result at pc %h where nothing should resolve", $time, res_pc);
            other_errors++;
         end
         if (res_mispredict !== 1'b0)
            report_mismatch("res_mispredict_o", 32'(res_mispredict), 32'd0);
      end
      foreach (exp_q[i])
         if (exp_q[i].pred_taken)
            pend++;                                  // targets still held in the buffer
      if (issue_ready !== (!flush_now && pend < BOP_SIZE))
         report_mismatch("issue_ready_o", 32'(issue_ready), 32'(!flush_now && pend < BOP_SIZE));
   endtask

   initial begin
      rst_n       = 1'b0;
      issue_valid = 1'b0;
      issue_op    = OP_ALU;
      {issue_pc, issue_a, issue_b, issue_offset} = '0;
      repeat (5) @(posedge clk);
      #1 rst_n = 1'b1;
      @(negedge clk);
      if (res_valid !== 1'b0)
         report_mismatch("res_valid_o", 32'(res_valid), 32'd0);
      if (res_mispredict !== 1'b0)
         report_mismatch("res_mispredict_o", 32'(res_mispredict), 32'd0);
      if (issue_ready !== 1'b1)
         report_mismatch("issue_ready_o", 32'(issue_ready), 32'd1);
      while (n_accepted < N_INSTR || exp_q.size() > 0) begin
         @(posedge clk);
         #1;
         if (accepted || !issue_valid)
            new_issue();                             // refused instruction held
         @(negedge clk);
         cyc++;
         check_cycle();
         accepted = issue_valid && issue_ready;
         if (accepted) begin
            exp_q.push_back(model_instr(cyc + 4));   // three edges after the accept edge
            n_accepted++;
         end
      end
      repeat (6) begin
         @(negedge clk);
         cyc++;
         check_cycle();
      end
      $display("issued %0d, flushes %0d, value errors %0d, other errors %0d, assert fails %0d",
               n_accepted, n_flushes, value_errors, other_errors,
               dut0.u_bop.u_props.fail_count);
      if (value_errors + other_errors + dut0.u_bop.u_props.fail_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // watchdog allows 8 cycles per instruction plus margin
   initial begin
      #(N_INSTR * 8 * CLK_PERIOD + 200 * CLK_PERIOD);
      $display("timeout: run exceeded its time budget for %0d instructions", N_INSTR);
      $display("Result: FAILED");
      $finish;
   end

endmodule

`default_nettype wire
